// File: pfb_ctrl.sv
//================================================
// Controller FSM: lookup, write-back, refill,
// array access and response sequencing
//================================================
`include "pfb_defines.svh"

module pfb_ctrl (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               accept,
  input  pfb_pkg::req_type_e req_type,
  input  logic               hit,
  input  logic               hit_way,
  input  logic               victim_way,
  input  logic               victim_dirty,
  input  logic               memresp_val,
  output logic               busy,
  output logic               tag_ren,
  output logic               way_sel,
  output logic               tag_wen,
  output logic               data_wen,
  output logic               is_refill,
  output logic               line_reg_en,
  output logic               victim_tag_en,
  output logic               mark_dirty,
  output logic               clear_dirty,
  output logic               lru_update,
  output pfb_pkg::req_type_e amo_op,
  output logic               resp_load,
  output logic               memreq_fire,
  output logic               memreq_is_write
);

  pfb_pkg::pfb_state_e state;
  pfb_pkg::pfb_state_e state_next;
  logic                way_q;
  logic                is_store;
  logic                in_access;

  // Anything other than a plain read modifies the line
  assign is_store  = (req_type != pfb_pkg::REQ_READ);
  assign in_access = (state == pfb_pkg::ST_ACCESS);

  //================================================
  // State and chosen way
  //================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= pfb_pkg::ST_IDLE;
      way_q <= 1'b0;
    end else begin
      state <= state_next;
      // Hit or victim way is fixed once the tags are checked
      if (tag_ren) begin
        way_q <= way_sel;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      pfb_pkg::ST_IDLE: begin
        if (accept) begin
          state_next = pfb_pkg::ST_TAG_CHECK;
        end
      end
      pfb_pkg::ST_TAG_CHECK: begin
        if (hit) begin
          state_next = pfb_pkg::ST_ACCESS;
        end else if (victim_dirty) begin
          state_next = pfb_pkg::ST_EVICT_REQ;
        end else begin
          state_next = pfb_pkg::ST_REFILL_REQ;
        end
      end
      pfb_pkg::ST_EVICT_REQ:  state_next = pfb_pkg::ST_EVICT_WAIT;
      pfb_pkg::ST_EVICT_WAIT: begin
        // Write-back acknowledge
        if (memresp_val) begin
          state_next = pfb_pkg::ST_REFILL_REQ;
        end
      end
      pfb_pkg::ST_REFILL_REQ:  state_next = pfb_pkg::ST_REFILL_WAIT;
      pfb_pkg::ST_REFILL_WAIT: begin
        if (memresp_val) begin
          state_next = pfb_pkg::ST_REFILL_WRITE;
        end
      end
      pfb_pkg::ST_REFILL_WRITE: state_next = pfb_pkg::ST_ACCESS;
      pfb_pkg::ST_ACCESS:       state_next = pfb_pkg::ST_RESPOND;
      pfb_pkg::ST_RESPOND: begin
        // Back-to-back request may follow the response
        state_next = accept ? pfb_pkg::ST_TAG_CHECK : pfb_pkg::ST_IDLE;
      end
      default: state_next = pfb_pkg::ST_IDLE;
    endcase
  end

  //================================================
  // Datapath and output controls
  //================================================
  assign busy    = (state != pfb_pkg::ST_IDLE) && (state != pfb_pkg::ST_RESPOND);
  assign tag_ren = (state == pfb_pkg::ST_TAG_CHECK);

  assign way_sel = tag_ren ? (hit ? hit_way : victim_way) : way_q;

  // Line register takes the looked-up line or the refill line
  assign line_reg_en   = tag_ren || is_refill;
  assign victim_tag_en = tag_ren && !hit;

  assign is_refill   = (state == pfb_pkg::ST_REFILL_WRITE);
  assign tag_wen     = is_refill;
  assign clear_dirty = is_refill;

  assign data_wen   = is_refill || (in_access && is_store);
  assign mark_dirty = in_access && is_store;
  assign lru_update = in_access;
  assign amo_op     = req_type;
  assign resp_load  = in_access;

  assign memreq_fire     = (state == pfb_pkg::ST_EVICT_REQ) ||
                           (state == pfb_pkg::ST_REFILL_REQ);
  assign memreq_is_write = (state == pfb_pkg::ST_EVICT_REQ);

endmodule

// File: pfb_defines.svh
//================================================
// Width and geometry macros for the prefetch
// buffer, with the address split into tag/index
//================================================
`ifndef PFB_DEFINES_SVH
`define PFB_DEFINES_SVH

// Requester and memory bus widths
`define PFB_ADDR_W 32
`define PFB_DATA_W 32
`define PFB_LINE_W 128
`define PFB_OPQ_W  8

// Two ways of 8 sets each
`define PFB_NSETS  8
`define PFB_IDX_W  3

// Selects one of the four words in a line
`define PFB_OFS_W  2

// Tag is whatever sits above the 16-byte line offset and the index
`define PFB_TAG_W  (`PFB_ADDR_W - 4 - `PFB_IDX_W)

`endif

// File: pfb_dpath.sv
//================================================
// Datapath: tag/data arrays, dirty and LRU state,
// refill register and atomic merge
//================================================
`include "pfb_defines.svh"

module pfb_dpath (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [`PFB_TAG_W-1:0]  req_tag,
  input  logic [`PFB_IDX_W-1:0]  req_idx,
  input  logic [`PFB_OFS_W-1:0]  req_ofs,
  input  logic [`PFB_DATA_W-1:0] req_data,
  input  logic                   memresp_val,
  input  logic [`PFB_LINE_W-1:0] memresp_data,
  input  logic                   tag_ren,
  input  logic                   way_sel,
  input  logic                   tag_wen,
  input  logic                   data_wen,
  input  logic                   is_refill,
  input  logic                   line_reg_en,
  input  logic                   victim_tag_en,
  input  logic                   mark_dirty,
  input  logic                   clear_dirty,
  input  logic                   lru_update,
  input  pfb_pkg::req_type_e     amo_op,
  output logic                   hit,
  output logic                   hit_way,
  output logic                   victim_way,
  output logic                   victim_dirty,
  output logic [`PFB_LINE_W-1:0] read_line,
  output logic [`PFB_TAG_W-1:0]  victim_tag,
  output logic [`PFB_DATA_W-1:0] old_word
);

  localparam int DW    = `PFB_DATA_W;
  localparam int WORDS = `PFB_LINE_W / `PFB_DATA_W;

  //================================================
  // Storage
  //================================================
  logic [`PFB_TAG_W-1:0]          tag_mem  [2][`PFB_NSETS];
  logic [`PFB_LINE_W-1:0]         data_mem [2*`PFB_NSETS];
  logic [1:0][`PFB_NSETS-1:0]     valid;
  logic [1:0][`PFB_NSETS-1:0]     dirty;
  logic [`PFB_NSETS-1:0]          lru;

  logic [1:0]                     match;
  logic [`PFB_IDX_W:0]            line_addr;
  logic [`PFB_LINE_W-1:0]         array_line;
  logic [`PFB_LINE_W-1:0]         mem_line;
  logic [`PFB_LINE_W-1:0]         fill_line;
  logic [WORDS-1:0]               word_en;
  logic [`PFB_DATA_W-1:0]         new_word;

  // Lookup on both ways at once
  assign match[0] = valid[0][req_idx] && (tag_mem[0][req_idx] == req_tag);
  assign match[1] = valid[1][req_idx] && (tag_mem[1][req_idx] == req_tag);
  assign hit      = tag_ren && (|match);
  assign hit_way  = match[1];

  // Empty way first, otherwise the LRU way
  always_comb begin
    if (!valid[0][req_idx]) begin
      victim_way = 1'b0;
    end else if (!valid[1][req_idx]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru[req_idx];
    end
  end

  assign victim_dirty = valid[victim_way][req_idx] && dirty[victim_way][req_idx];

  // Lines of one set sit next to each other
  assign line_addr  = {req_idx, way_sel};
  assign array_line = data_mem[line_addr];

  //================================================
  // Line, refill and victim registers
  //================================================
  always_ff @(posedge clk) begin
    if (memresp_val) begin
      mem_line <= memresp_data;
    end
    if (line_reg_en) begin
      read_line <= is_refill ? mem_line : array_line;
    end
    if (victim_tag_en) begin
      victim_tag <= tag_mem[way_sel][req_idx];
    end
  end

  assign old_word = read_line[req_ofs*DW +: DW];

  // Atomic unit
  always_comb begin
    case (amo_op)
      pfb_pkg::REQ_AMO_ADD: new_word = old_word + req_data;
      pfb_pkg::REQ_AMO_AND: new_word = old_word & req_data;
      pfb_pkg::REQ_AMO_OR:  new_word = old_word | req_data;
      default:              new_word = req_data;
    endcase
  end

  // Store word goes to every slot, only the addressed one is enabled
  assign fill_line = is_refill ? mem_line : {WORDS{new_word}};
  assign word_en   = is_refill ? {WORDS{1'b1}} : ({{(WORDS-1){1'b0}}, 1'b1} << req_ofs);

  always_ff @(posedge clk) begin
    if (data_wen) begin
      for (int i = 0; i < WORDS; i++) begin
        if (word_en[i]) begin
          data_mem[line_addr][i*DW +: DW] <= fill_line[i*DW +: DW];
        end
      end
    end
    if (tag_wen) begin
      tag_mem[way_sel][req_idx] <= req_tag;
    end
  end

  //================================================
  // Valid, dirty and LRU bits
  //================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (tag_wen) begin
        valid[way_sel][req_idx] <= 1'b1;
      end
      if (mark_dirty) begin
        dirty[way_sel][req_idx] <= 1'b1;
      end else if (clear_dirty) begin
        dirty[way_sel][req_idx] <= 1'b0;
      end
      // lru holds the way to evict next
      if (lru_update) begin
        lru[req_idx] <= ~way_sel;
      end
    end
  end

endmodule

// File: pfb_pkg.sv
//================================================
// Shared types: requester operations, memory
// operations and controller states
//================================================
package pfb_pkg;

  // Operations a requester may issue
  typedef enum logic [2:0] {
    REQ_READ    = 3'd0,
    REQ_WRITE   = 3'd1,
    REQ_AMO_ADD = 3'd2,
    REQ_AMO_AND = 3'd3,
    REQ_AMO_OR  = 3'd4
  } req_type_e;

  // Whole-line memory operations
  typedef enum logic [0:0] {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_type_e;

  // Controller FSM states
  typedef enum logic [3:0] {
    ST_IDLE         = 4'd0,
    ST_TAG_CHECK    = 4'd1,
    ST_EVICT_REQ    = 4'd2,
    ST_EVICT_WAIT   = 4'd3,
    ST_REFILL_REQ   = 4'd4,
    ST_REFILL_WAIT  = 4'd5,
    ST_REFILL_WRITE = 4'd6,
    ST_ACCESS       = 4'd7,
    ST_RESPOND      = 4'd8
  } pfb_state_e;

endpackage

// File: pfb_req_capture.sv
//================================================
// Request capture: accept strobe and address split
//================================================
`include "pfb_defines.svh"

module pfb_req_capture (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cachereq_val,
  input  pfb_pkg::req_type_e     cachereq_type,
  input  logic [`PFB_OPQ_W-1:0]  cachereq_opaque,
  input  logic [`PFB_ADDR_W-1:0] cachereq_addr,
  input  logic [`PFB_DATA_W-1:0] cachereq_data,
  input  logic                   busy,
  output logic                   accept,
  output pfb_pkg::req_type_e     req_type,
  output logic [`PFB_OPQ_W-1:0]  req_opaque,
  output logic [`PFB_TAG_W-1:0]  req_tag,
  output logic [`PFB_IDX_W-1:0]  req_idx,
  output logic [`PFB_OFS_W-1:0]  req_ofs,
  output logic [`PFB_DATA_W-1:0] req_data
);

  // A strobe that lands while busy is dropped
  assign accept = cachereq_val && !busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_type   <= pfb_pkg::REQ_READ;
      req_opaque <= '0;
    end else if (accept) begin
      req_type   <= cachereq_type;
      req_opaque <= cachereq_opaque;
    end
  end

  // Tag, set index and word offset
  // The two byte-select bits are not kept
  always_ff @(posedge clk) begin
    if (accept) begin
      req_tag  <= cachereq_addr[`PFB_ADDR_W-1 -: `PFB_TAG_W];
      req_idx  <= cachereq_addr[(2 + `PFB_OFS_W) +: `PFB_IDX_W];
      req_ofs  <= cachereq_addr[2 +: `PFB_OFS_W];
      req_data <= cachereq_data;
    end
  end

endmodule

// File: pfb_resp_format.sv
//================================================
// Output side: registered cache response and
// line-wide memory request
//================================================
`include "pfb_defines.svh"

module pfb_resp_format (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   resp_load,
  input  logic                   memreq_fire,
  input  logic                   memreq_is_write,
  input  pfb_pkg::req_type_e     req_type,
  input  logic [`PFB_OPQ_W-1:0]  req_opaque,
  input  logic [`PFB_TAG_W-1:0]  req_tag,
  input  logic [`PFB_IDX_W-1:0]  req_idx,
  input  logic [`PFB_OFS_W-1:0]  req_ofs,
  input  logic [`PFB_DATA_W-1:0] old_word,
  input  logic [`PFB_LINE_W-1:0] read_line,
  input  logic [`PFB_TAG_W-1:0]  victim_tag,
  output logic                   cacheresp_val,
  output pfb_pkg::req_type_e     cacheresp_type,
  output logic [`PFB_OPQ_W-1:0]  cacheresp_opaque,
  output logic [`PFB_DATA_W-1:0] cacheresp_data,
  output logic                   memreq_val,
  output pfb_pkg::mem_type_e     memreq_type,
  output logic [`PFB_ADDR_W-1:0] memreq_addr,
  output logic [`PFB_LINE_W-1:0] memreq_data
);

  logic [`PFB_DATA_W-1:0] read_word;
  logic [`PFB_TAG_W-1:0]  line_tag;

  assign read_word = read_line[req_ofs*`PFB_DATA_W +: `PFB_DATA_W];
  // Write-back goes to the victim's address
  assign line_tag  = memreq_is_write ? victim_tag : req_tag;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cacheresp_val <= 1'b0;
      memreq_val    <= 1'b0;
    end else begin
      cacheresp_val <= resp_load;
      memreq_val    <= memreq_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_load) begin
      cacheresp_type   <= req_type;
      cacheresp_opaque <= req_opaque;
      case (req_type)
        pfb_pkg::REQ_READ:  cacheresp_data <= read_word;
        pfb_pkg::REQ_WRITE: cacheresp_data <= '0;
        default:            cacheresp_data <= old_word;
      endcase
    end
    if (memreq_fire) begin
      memreq_type <= memreq_is_write ? pfb_pkg::MEM_WRITE : pfb_pkg::MEM_READ;
      memreq_addr <= {line_tag, req_idx, {(`PFB_OFS_W + 2){1'b0}}};
      memreq_data <= memreq_is_write ? read_line : '0;
    end
  end

endmodule

// File: prefetch_buffer.sv
//================================================
// Prefetch buffer top: capture, controller,
// datapath and output stage
//================================================
`include "pfb_defines.svh"

module prefetch_buffer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cachereq_val,
  input  pfb_pkg::req_type_e     cachereq_type,
  input  logic [`PFB_OPQ_W-1:0]  cachereq_opaque,
  input  logic [`PFB_ADDR_W-1:0] cachereq_addr,
  input  logic [`PFB_DATA_W-1:0] cachereq_data,
  output logic                   cacheresp_val,
  output pfb_pkg::req_type_e     cacheresp_type,
  output logic [`PFB_OPQ_W-1:0]  cacheresp_opaque,
  output logic [`PFB_DATA_W-1:0] cacheresp_data,
  output logic                   busy,
  output logic                   memreq_val,
  output pfb_pkg::mem_type_e     memreq_type,
  output logic [`PFB_ADDR_W-1:0] memreq_addr,
  output logic [`PFB_LINE_W-1:0] memreq_data,
  input  logic                   memresp_val,
  input  logic [`PFB_LINE_W-1:0] memresp_data
);

  // Captured request fields
  logic                   accept;
  pfb_pkg::req_type_e     req_type;
  logic [`PFB_OPQ_W-1:0]  req_opaque;
  logic [`PFB_TAG_W-1:0]  req_tag;
  logic [`PFB_IDX_W-1:0]  req_idx;
  logic [`PFB_OFS_W-1:0]  req_ofs;
  logic [`PFB_DATA_W-1:0] req_data;

  // Controller to datapath
  logic tag_ren, way_sel, tag_wen, data_wen, is_refill;
  logic line_reg_en, victim_tag_en, mark_dirty, clear_dirty, lru_update;
  pfb_pkg::req_type_e amo_op;

  // Datapath status and output-side controls
  logic hit, hit_way, victim_way, victim_dirty;
  logic resp_load, memreq_fire, memreq_is_write;
  logic [`PFB_LINE_W-1:0] read_line;
  logic [`PFB_TAG_W-1:0]  victim_tag;
  logic [`PFB_DATA_W-1:0] old_word;

  pfb_req_capture req_capture_inst (
    .clk, .arst_n, .cachereq_val, .cachereq_type, .cachereq_opaque,
    .cachereq_addr, .cachereq_data, .busy, .accept, .req_type,
    .req_opaque, .req_tag, .req_idx, .req_ofs, .req_data
  );

  pfb_ctrl ctrl_inst (
    .clk, .arst_n, .accept, .req_type, .hit, .hit_way, .victim_way,
    .victim_dirty, .memresp_val, .busy, .tag_ren, .way_sel, .tag_wen,
    .data_wen, .is_refill, .line_reg_en, .victim_tag_en, .mark_dirty,
    .clear_dirty, .lru_update, .amo_op, .resp_load, .memreq_fire,
    .memreq_is_write
  );

  pfb_dpath dpath_inst (
    .clk, .arst_n, .req_tag, .req_idx, .req_ofs, .req_data, .memresp_val,
    .memresp_data, .tag_ren, .way_sel, .tag_wen, .data_wen, .is_refill,
    .line_reg_en, .victim_tag_en, .mark_dirty, .clear_dirty, .lru_update,
    .amo_op, .hit, .hit_way, .victim_way, .victim_dirty, .read_line,
    .victim_tag, .old_word
  );

  pfb_resp_format resp_format_inst (
    .clk, .arst_n, .resp_load, .memreq_fire, .memreq_is_write, .req_type,
    .req_opaque, .req_tag, .req_idx, .req_ofs, .old_word, .read_line,
    .victim_tag, .cacheresp_val, .cacheresp_type, .cacheresp_opaque,
    .cacheresp_data, .memreq_val, .memreq_type, .memreq_addr, .memreq_data
  );

endmodule

// File: prefetch_buffer_sva.sv
//==================================================
// Concurrent checks on request strobes, busy and
// hit response timing, bound into the top level
//==================================================
module prefetch_buffer_sva (
  input logic clk,
  input logic arst_n,
  input logic cachereq_val,
  input logic busy,
  input logic accept,
  input logic hit,
  input logic cacheresp_val,
  input logic memreq_val
);
  timeunit 1ns;
  timeprecision 100ps;

  logic open_txn;
  logic accept_q;

  // Open from acceptance until the response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      open_txn <= 1'b0;
      accept_q <= 1'b0;
    end else begin
      accept_q <= accept;
      if (accept) begin
        open_txn <= 1'b1;
      end else if (cacheresp_val) begin
        open_txn <= 1'b0;
      end
    end
  end

  single_accept: assert property (@(posedge clk) disable iff (!arst_n)
    accept |-> (!open_txn || cacheresp_val))
    else $error("second request accepted within one transaction");

  no_req_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> !cachereq_val)
    else $error("cachereq_val strobed while busy");

  resp_memreq_apart: assert property (@(posedge clk) disable iff (!arst_n)
    !(memreq_val && cacheresp_val))
    else $error("memreq_val and cacheresp_val high together");

  // Hit is seen in the cycle after acceptance
  hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
    (accept_q && hit) |-> ##2 cacheresp_val)
    else $error("hit response not 3 cycles after acceptance");

endmodule

bind prefetch_buffer prefetch_buffer_sva prefetch_buffer_sva_inst (
  .clk, .arst_n, .cachereq_val, .busy, .accept, .hit, .cacheresp_val, .memreq_val
);

// File: project.f
+incdir+.
pfb_pkg.sv
pfb_req_capture.sv
pfb_ctrl.sv
pfb_dpath.sv
pfb_resp_format.sv
prefetch_buffer.sv
prefetch_buffer_sva.sv
tb_prefetch_buffer.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the prefetch buffer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
  --top-module tb_prefetch_buffer -f project.f -o sim_prefetch_buffer

./obj_dir/sim_prefetch_buffer | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

// File: tb_prefetch_buffer.sv
//==================================================
// Prefetch buffer testbench with LFSR stimulus, a
// line memory model and a flat word reference model
//==================================================
`include "pfb_defines.svh"

module tb_prefetch_buffer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TAG_W = `PFB_TAG_W;
  localparam int TIMEOUT = 200;

  logic                   clk;
  logic                   arst_n;
  logic                   cachereq_val;
  pfb_pkg::req_type_e     cachereq_type;
  logic [`PFB_OPQ_W-1:0]  cachereq_opaque;
  logic [`PFB_ADDR_W-1:0] cachereq_addr;
  logic [`PFB_DATA_W-1:0] cachereq_data;
  logic                   cacheresp_val;
  pfb_pkg::req_type_e     cacheresp_type;
  logic [`PFB_OPQ_W-1:0]  cacheresp_opaque;
  logic [`PFB_DATA_W-1:0] cacheresp_data;
  logic                   busy;
  logic                   memreq_val;
  pfb_pkg::mem_type_e     memreq_type;
  logic [`PFB_ADDR_W-1:0] memreq_addr;
  logic [`PFB_LINE_W-1:0] memreq_data;
  logic                   memresp_val;
  logic [`PFB_LINE_W-1:0] memresp_data;

  // Line memory by line address and reference words by word address
  logic [`PFB_LINE_W-1:0] mem_lines [logic [27:0]];
  logic [31:0]            ref_words [logic [29:0]];
  logic [31:0]            lfsr_state;
  logic                   mem_pending;
  logic [27:0]            mem_line_addr;
  logic [27:0]            last_wb_line;
  int                     mem_delay;
  int                     memreq_count;
  int                     wb_count;
  int                     checks;
  int                     errors;
  logic                   hung;

  prefetch_buffer prefetch_buffer_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //==================================================
  // Random numbers and address pool
  //==================================================
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'hB4BC_D35C;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // Pool tag k in set idx, word ofs
  function automatic logic [31:0] pool_addr(input logic [2:0] k, input logic [2:0] idx,
                                            input logic [1:0] ofs);
    logic [TAG_W-1:0] tag;
    tag = TAG_W'(32'h0001_2c40 + 32'(k) * 32'd7);
    return {tag, idx, ofs, 2'b00};
  endfunction

  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = rand_bits(7);
    return pool_addr({1'b0, r[6:5]}, r[4:2], r[1:0]);
  endfunction

  //==================================================
  // Memory contents and reference model
  //==================================================
  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return (addr ^ 32'h3c5a_96e1) + {addr[7:0], addr[31:8]};
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    if (ref_words.exists(addr[31:2])) begin
      return ref_words[addr[31:2]];
    end
    return init_word({addr[31:2], 2'b00});
  endfunction

  function automatic logic [`PFB_LINE_W-1:0] line_read(input logic [27:0] la);
    logic [`PFB_LINE_W-1:0] l;
    if (mem_lines.exists(la)) begin
      return mem_lines[la];
    end
    for (int i = 0; i < 4; i++) begin
      l[i*32 +: 32] = init_word({la, 2'(i), 2'b00});
    end
    return l;
  endfunction

  // Applies one operation and returns the expected response word
  function automatic logic [31:0] apply_ref(input pfb_pkg::req_type_e t,
                                            input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] old;
    old = ref_read(addr);
    case (t)
      pfb_pkg::REQ_READ:    ;
      pfb_pkg::REQ_WRITE:   ref_words[addr[31:2]] = data;
      pfb_pkg::REQ_AMO_ADD: ref_words[addr[31:2]] = old + data;
      pfb_pkg::REQ_AMO_AND: ref_words[addr[31:2]] = old & data;
      default:              ref_words[addr[31:2]] = old | data;
    endcase
    return (t == pfb_pkg::REQ_WRITE) ? 32'h0 : old;
  endfunction

  //==================================================
  // Clock step with the memory model
  //==================================================
  task automatic tick();
    @(posedge clk);
    #2;
    memresp_val = 1'b0;
    if (mem_pending) begin
      if (mem_delay == 0) begin
        memresp_val  = 1'b1;
        memresp_data = line_read(mem_line_addr);
        mem_pending  = 1'b0;
      end else begin
        mem_delay--;
      end
    end
    if (memreq_val) begin
      memreq_count++;
      mem_line_addr = memreq_addr[31:4];
      if (memreq_type == pfb_pkg::MEM_WRITE) begin
        mem_lines[mem_line_addr] = memreq_data;
        last_wb_line = mem_line_addr;
        wb_count++;
      end
      // Answer after 1 to 8 cycles
      mem_pending = 1'b1;
      mem_delay   = int'(rand_bits(3));
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (busy) begin
      $display("Timeout at %0t: the buffer stayed busy for %0d cycles", $time, TIMEOUT);
      hung = 1'b1;
      errors++;
    end
  endtask

  // One request through the DUT with lat as edges from acceptance to response
  task automatic run_op(input pfb_pkg::req_type_e t, input logic [31:0] addr,
                        input logic [31:0] data, output int lat, output int mreqs);
    logic [31:0] exp_data;
    logic [31:0] opq;
    int          n;
    int          mark;
    lat   = 0;
    mreqs = 0;
    if (hung) return;
    wait_idle();
    if (hung) return;
    exp_data        = apply_ref(t, addr, data);
    opq             = rand_bits(8);
    cachereq_val    = 1'b1;
    cachereq_type   = t;
    cachereq_opaque = opq[7:0];
    cachereq_addr   = addr;
    cachereq_data   = data;
    tick();
    cachereq_val = 1'b0;
    checks++;
    if (busy !== 1'b1) begin
      errors++;
      $display("[ERROR] %0t: busy is %b in the cycle after acceptance of %s at %h",
               $time, busy, t.name(), addr);
    end
    mark = memreq_count;
    n = 0;
    while (!cacheresp_val && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (!cacheresp_val) begin
      $display("Timeout at %0t: no response to %s at %h", $time, t.name(), addr);
      hung = 1'b1;
      errors++;
      return;
    end
    lat   = n + 1;
    mreqs = memreq_count - mark;
    checks++;
    if (busy !== 1'b0) begin
      errors++;
      $display("[ERROR] %0t: busy is %b together with the response to %s at %h",
               $time, busy, t.name(), addr);
    end
    checks++;
    if (cacheresp_data !== exp_data || cacheresp_opaque !== opq[7:0] ||
        cacheresp_type !== t) begin
      errors++;
      $display("[ERROR] %0t: %s at %h gave data %h opaque %h type %0d, expected %h %h %0d",
               $time, t.name(), addr, cacheresp_data, cacheresp_opaque, cacheresp_type,
               exp_data, opq[7:0], t);
    end
  endtask

  task automatic report(input string name, input int err_before);
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  //==================================================
  // Tests
  //==================================================
  task automatic idle_after_reset();
    int e;
    e = errors;
    for (int i = 0; i < 6; i++) begin
      tick();
      checks++;
      if (cacheresp_val !== 1'b0 || memreq_val !== 1'b0 || busy !== 1'b0) begin
        errors++;
        $display("[ERROR] %0t: not idle after reset, resp %b memreq %b busy %b",
                 $time, cacheresp_val, memreq_val, busy);
      end
    end
    report("reset_idle", e);
  endtask

  task automatic random_reads();
    int e;
    int lat;
    int mreqs;
    e = errors;
    for (int i = 0; i < 40; i++) begin
      run_op(pfb_pkg::REQ_READ, rand_addr(), 32'h0, lat, mreqs);
    end
    report("random_reads", e);
  endtask

  task automatic write_then_read();
    int          e;
    int          lat;
    int          mreqs;
    logic [31:0] a;
    e = errors;
    for (int i = 0; i < 16; i++) begin
      a = rand_addr();
      run_op(pfb_pkg::REQ_WRITE, a, rand_bits(32), lat, mreqs);
      run_op(pfb_pkg::REQ_READ, a, 32'h0, lat, mreqs);
    end
    report("write_read", e);
  endtask

  task automatic atomic_ops();
    int                 e;
    int                 lat;
    int                 mreqs;
    logic [31:0]        a;
    pfb_pkg::req_type_e op;
    e = errors;
    for (int i = 0; i < 12; i++) begin
      a = rand_addr();
      case (i % 3)
        0:       op = pfb_pkg::REQ_AMO_ADD;
        1:       op = pfb_pkg::REQ_AMO_AND;
        default: op = pfb_pkg::REQ_AMO_OR;
      endcase
      run_op(op, a, rand_bits(32), lat, mreqs);
      run_op(pfb_pkg::REQ_READ, a, 32'h0, lat, mreqs);
    end
    report("atomics", e);
  endtask

  // Two dirty lines and a third tag that pushes out the older one
  task automatic dirty_eviction();
    int                     e;
    int                     lat;
    int                     mreqs;
    int                     wb_mark;
    logic [31:0]            r;
    logic [31:0]            a0;
    logic [`PFB_LINE_W-1:0] l;
    e  = errors;
    r  = rand_bits(5);
    a0 = pool_addr(3'd4, r[4:2], r[1:0]);
    run_op(pfb_pkg::REQ_WRITE, a0, rand_bits(32), lat, mreqs);
    run_op(pfb_pkg::REQ_WRITE, pool_addr(3'd5, r[4:2], r[1:0]), rand_bits(32), lat, mreqs);
    wb_mark = wb_count;
    run_op(pfb_pkg::REQ_READ, pool_addr(3'd6, r[4:2], r[1:0]), 32'h0, lat, mreqs);
    if (!hung) begin
      checks++;
      if (wb_count != wb_mark + 1 || last_wb_line != a0[31:4]) begin
        errors++;
        $display("[ERROR] %0t: no write-back of line %h (%0d write-backs, last %h)",
                 $time, a0[31:4], wb_count - wb_mark, last_wb_line);
      end else begin
        l = line_read(a0[31:4]);
        for (int i = 0; i < 4; i++) begin
          checks++;
          if (l[i*32 +: 32] !== ref_read({a0[31:4], 2'(i), 2'b00})) begin
            errors++;
            $display("[ERROR] %0t: written-back word %0d is %h, expected %h", $time, i,
                     l[i*32 +: 32], ref_read({a0[31:4], 2'(i), 2'b00}));
          end
        end
      end
    end
    run_op(pfb_pkg::REQ_READ, a0, 32'h0, lat, mreqs);
    report("eviction", e);
  endtask

  task automatic repeated_read_hits();
    int          e;
    int          lat;
    int          mreqs;
    logic [31:0] a;
    e = errors;
    for (int i = 0; i < 8; i++) begin
      a = rand_addr();
      run_op(pfb_pkg::REQ_READ, a, 32'h0, lat, mreqs);
      run_op(pfb_pkg::REQ_READ, a, 32'h0, lat, mreqs);
      checks++;
      if (!hung && (lat != 3 || mreqs != 0)) begin
        errors++;
        $display("[ERROR] %0t: repeated read of %h took %0d cycles with %0d memory requests",
                 $time, a, lat, mreqs);
      end
    end
    report("hit_timing", e);
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    arst_n          = 1'b0;
    cachereq_val    = 1'b0;
    cachereq_type   = pfb_pkg::REQ_READ;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    memresp_val     = 1'b0;
    memresp_data    = '0;
    lfsr_state      = 32'h05fae7a3;
    mem_pending     = 1'b0;
    mem_line_addr   = '0;
    last_wb_line    = '0;
    mem_delay       = 0;
    memreq_count    = 0;
    wb_count        = 0;
    checks          = 0;
    errors          = 0;
    hung            = 1'b0;
    repeat (4) tick();
    arst_n = 1'b1;
    idle_after_reset();
    random_reads();
    write_then_read();
    atomic_ops();
    dirty_eviction();
    repeated_read_hits();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
